// File: include/rotator_config.svh
// build-time sizes for the weight rotator
// array geometry, header field widths and bank depth
`ifndef ROTATOR_CONFIG_SVH
`define ROTATOR_CONFIG_SVH

// one beat feeds every array column
`define ROT_COLS        8
`define ROT_WORD_WIDTH  8

// header field widths
`define ROT_KW2_BITS    2
`define ROT_KH2_BITS    2
`define ROT_CIN_BITS    5
`define ROT_COLS_BITS   4
`define ROT_BLOCKS_BITS 3

// weight bank size
`define ROT_BANK_DEPTH  128
`define ROT_ADDR_BITS   7   // log2 of bank depth

`endif

// File: verilog/rotator_pkg.sv
// shared types of the weight rotator
// beat, address, header and sideband structs, fsm state enums
`default_nettype none

`include "rotator_config.svh"

package rotator_pkg;

  typedef logic [`ROT_COLS*`ROT_WORD_WIDTH-1:0] beat_t;
  typedef logic [`ROT_ADDR_BITS-1:0]            addr_t;

  // header beat layout with kw2 in the lowest bits
  typedef struct packed {
    logic [`ROT_BLOCKS_BITS-1:0] blocks_1;
    logic [`ROT_COLS_BITS-1:0]   cols_1;
    logic [`ROT_CIN_BITS-1:0]    cin_1;
    logic [`ROT_KH2_BITS-1:0]    kh2;
    logic [`ROT_KW2_BITS-1:0]    kw2;
  } rot_ref_t;

  typedef struct packed {
    logic [`ROT_KW2_BITS-1:0] kw2;
    logic                     is_cin_last;   // end of one pass
    logic                     is_col_last;
    logic                     is_top_block;
    logic                     is_bot_block;
  } rot_user_t;

  typedef struct packed {
    beat_t     data;
    rot_user_t user;
    logic      last;
  } rot_out_t;

  typedef enum logic [1:0] {
    ws_idle,
    ws_get_ref,
    ws_write,
    ws_switch
  } write_state_e;

  typedef enum logic [1:0] {
    rs_idle,
    rs_read,
    rs_drain,
    rs_switch
  } read_state_e;

endpackage

`default_nettype wire

// File: verilog/weight_bank.sv
// one weight bank
// simple dual-port memory, registered read port held between reads
`timescale 1ns/10ps
`default_nettype none

`include "rotator_config.svh"

module weight_bank (
  input  wire                 i_aclk,
  input  wire                 i_rst_n,
  input  wire                 i_wen,
  input  wire rotator_pkg::addr_t i_waddr,
  input  wire rotator_pkg::beat_t i_wdata,
  input  wire                 i_ren,
  input  wire rotator_pkg::addr_t i_raddr,
  output rotator_pkg::beat_t  o_rdata
);

  rotator_pkg::beat_t mem [`ROT_BANK_DEPTH];

  always_ff @(posedge i_aclk) begin
    if (i_wen) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // read register only moves on a read issue
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rdata <= '0;
    end else if (i_ren) begin
      o_rdata <= mem[i_raddr];
    end
  end

endmodule

`default_nettype wire

// File: verilog/bank_write_ctrl.sv
// write side of the ping-pong buffer
// write fsm, per-bank header registers, full flags, write address
`timescale 1ns/10ps
`default_nettype none

module bank_write_ctrl (
  input  wire                      i_aclk,
  input  wire                      i_rst_n,
  input  wire                      i_s_valid,
  input  wire                      i_s_last,
  input  wire rotator_pkg::beat_t  i_s_data,
  output logic                     o_s_ready,
  output logic [1:0]               o_wen,
  output rotator_pkg::addr_t       o_waddr,
  output logic [1:0]               o_full,
  output rotator_pkg::rot_ref_t    o_ref0,
  output rotator_pkg::rot_ref_t    o_ref1,
  input  wire                      i_release
);

  rotator_pkg::write_state_e state_q, state_d;
  rotator_pkg::rot_ref_t     ref_q [2];
  rotator_pkg::addr_t        waddr_q;
  logic [1:0]                full_q;
  logic                      wsel_q;     // bank being filled
  logic                      rel_sel_q;  // oldest full bank which is released next
  logic                      s_hs;
  logic                      wr_hs;

  assign o_s_ready = (state_q == rotator_pkg::ws_get_ref) || (state_q == rotator_pkg::ws_write);
  assign s_hs      = i_s_valid && o_s_ready;
  assign wr_hs     = s_hs && (state_q == rotator_pkg::ws_write);

  assign o_wen   = {wr_hs && wsel_q, wr_hs && !wsel_q};
  assign o_waddr = waddr_q;
  assign o_full  = full_q;
  assign o_ref0  = ref_q[0];
  assign o_ref1  = ref_q[1];

  always_comb begin
    state_d = state_q;
    case (state_q)
      rotator_pkg::ws_idle:    if (!full_q[wsel_q]) state_d = rotator_pkg::ws_get_ref;
      rotator_pkg::ws_get_ref: if (s_hs) state_d = rotator_pkg::ws_write;
      rotator_pkg::ws_write:   if (wr_hs && i_s_last) state_d = rotator_pkg::ws_switch;
      rotator_pkg::ws_switch:  state_d = rotator_pkg::ws_idle;
      default:                 state_d = rotator_pkg::ws_idle;
    endcase
  end

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q   <= rotator_pkg::ws_idle;
      wsel_q    <= 1'b0;
      rel_sel_q <= 1'b0;
      full_q    <= 2'b00;
      waddr_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == rotator_pkg::ws_switch) wsel_q <= ~wsel_q;
      if (i_release) begin
        rel_sel_q         <= ~rel_sel_q;
        full_q[rel_sel_q] <= 1'b0;
      end
      if (wr_hs && i_s_last) full_q[wsel_q] <= 1'b1;  // bank handed to reader
      if (state_q == rotator_pkg::ws_get_ref) begin
        waddr_q <= '0;
      end else if (wr_hs) begin
        waddr_q <= waddr_q + 1'b1;
      end
    end
  end

  // header taken from the low bits of the first beat
  always_ff @(posedge i_aclk) begin
    if (s_hs && (state_q == rotator_pkg::ws_get_ref)) begin
      ref_q[wsel_q] <= i_s_data[$bits(rotator_pkg::rot_ref_t)-1:0];
    end
  end

endmodule

`default_nettype wire

// File: verilog/rotation_counter.sv
// nested down-counters for one bank read-out
// kernel rows -> channels -> columns -> blocks
// drives read address, sideband flags and last
`timescale 1ns/10ps
`default_nettype none

`include "rotator_config.svh"

module rotation_counter (
  input  wire                      i_aclk,
  input  wire                      i_rst_n,
  input  wire                      i_load,
  input  wire                      i_step,
  input  wire rotator_pkg::rot_ref_t i_ref,
  output rotator_pkg::addr_t       o_raddr,
  output rotator_pkg::rot_user_t   o_user,
  output logic                     o_last
);

  logic [`ROT_KH2_BITS:0]      kh_q;    // holds up to 2*kh2
  logic [`ROT_CIN_BITS-1:0]    cin_q;
  logic [`ROT_COLS_BITS-1:0]   col_q;
  logic [`ROT_BLOCKS_BITS-1:0] blk_q;
  rotator_pkg::addr_t          addr_q;
  logic [`ROT_KH2_BITS:0]      kh_init;

  logic kh_zero, cin_zero, col_zero, blk_zero;
  logic pass_end;

  assign kh_init  = {i_ref.kh2, 1'b0};
  assign kh_zero  = (kh_q == '0);
  assign cin_zero = (cin_q == '0);
  assign col_zero = (col_q == '0);
  assign blk_zero = (blk_q == '0);
  assign pass_end = kh_zero && cin_zero;

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      kh_q   <= '0;
      cin_q  <= '0;
      col_q  <= '0;
      blk_q  <= '0;
      addr_q <= '0;
    end else if (i_load) begin
      kh_q   <= kh_init;
      cin_q  <= i_ref.cin_1;
      col_q  <= i_ref.cols_1;
      blk_q  <= i_ref.blocks_1;
      addr_q <= '0;
    end else if (i_step) begin
      kh_q <= kh_zero ? kh_init : kh_q - 1'b1;
      if (kh_zero) begin
        cin_q <= cin_zero ? i_ref.cin_1 : cin_q - 1'b1;
      end
      if (pass_end) begin
        col_q <= col_zero ? i_ref.cols_1 : col_q - 1'b1;
      end
      if (pass_end && col_zero) begin
        blk_q <= blk_zero ? i_ref.blocks_1 : blk_q - 1'b1;
      end
      addr_q <= pass_end ? '0 : addr_q + 1'b1;  // every pass rereads the bank from zero
    end
  end

  // flags describe the beat issued in this cycle
  assign o_raddr             = addr_q;
  assign o_user.kw2          = i_ref.kw2;
  assign o_user.is_cin_last  = pass_end;
  assign o_user.is_col_last  = col_zero;
  assign o_user.is_top_block = (blk_q == i_ref.blocks_1);
  assign o_user.is_bot_block = blk_zero;
  assign o_last              = pass_end && col_zero && blk_zero;

endmodule

`default_nettype wire

// File: verilog/bank_read_ctrl.sv
// read side of the ping-pong buffer
// read fsm, read bank select, read issue and bank release
`timescale 1ns/10ps
`default_nettype none

module bank_read_ctrl (
  input  wire                      i_aclk,
  input  wire                      i_rst_n,
  input  wire [1:0]                i_full,
  input  wire rotator_pkg::rot_ref_t i_ref0,
  input  wire rotator_pkg::rot_ref_t i_ref1,
  input  wire                      i_room,
  input  wire                      i_skid_empty,
  output logic [1:0]               o_ren,
  output rotator_pkg::addr_t       o_raddr,
  output logic                     o_issue,
  output rotator_pkg::rot_user_t   o_user,
  output logic                     o_last,
  output logic                     o_release
);

  rotator_pkg::read_state_e state_q, state_d;
  rotator_pkg::rot_ref_t    ref_sel;
  logic                     rsel_q;   // bank being read
  logic                     load;

  assign ref_sel   = rsel_q ? i_ref1 : i_ref0;
  assign load      = (state_q == rotator_pkg::rs_idle) && i_full[rsel_q];
  assign o_issue   = (state_q == rotator_pkg::rs_read) && i_room;
  assign o_ren     = {o_issue && rsel_q, o_issue && !rsel_q};
  assign o_release = (state_q == rotator_pkg::rs_switch);

  rotation_counter u_counter (
    .i_aclk  (i_aclk),
    .i_rst_n (i_rst_n),
    .i_load  (load),
    .i_step  (o_issue),
    .i_ref   (ref_sel),
    .o_raddr (o_raddr),
    .o_user  (o_user),
    .o_last  (o_last)
  );

  always_comb begin
    state_d = state_q;
    case (state_q)
      rotator_pkg::rs_idle:   if (load) state_d = rotator_pkg::rs_read;
      rotator_pkg::rs_read:   if (o_issue && o_last) state_d = rotator_pkg::rs_drain;
      rotator_pkg::rs_drain:  if (i_skid_empty) state_d = rotator_pkg::rs_switch;
      rotator_pkg::rs_switch: state_d = rotator_pkg::rs_idle;
      default:                state_d = rotator_pkg::rs_idle;
    endcase
  end

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= rotator_pkg::rs_idle;
      rsel_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == rotator_pkg::rs_switch) rsel_q <= ~rsel_q;
    end
  end

endmodule

`default_nettype wire

// File: verilog/output_skid.sv
// output buffer behind the weight banks
// aligns sideband with bank data, two-entry fifo, valid/ready output
`timescale 1ns/10ps
`default_nettype none

module output_skid (
  input  wire                       i_aclk,
  input  wire                       i_rst_n,
  input  wire                       i_issue,
  input  wire rotator_pkg::beat_t   i_data,
  input  wire rotator_pkg::rot_user_t i_user,
  input  wire                       i_last,
  output logic                      o_room,
  output logic                      o_empty,
  output logic                      o_m_valid,
  input  wire                       i_m_ready,
  output rotator_pkg::beat_t        o_m_data,
  output rotator_pkg::rot_user_t    o_m_user,
  output logic                      o_m_last
);

  rotator_pkg::rot_out_t  buf_q [2];
  rotator_pkg::rot_out_t  in_item;
  rotator_pkg::rot_out_t  out_item;
  rotator_pkg::rot_user_t pend_user_q;
  logic                   pend_last_q;
  logic                   pend_q;     // item in flight whose data lands this cycle
  logic [1:0]             cnt_q;
  logic [1:0]             total;
  logic                   wr_ptr_q, rd_ptr_q;
  logic                   bypass, push, pop;

  assign in_item  = '{data: i_data, user: pend_user_q, last: pend_last_q};
  assign out_item = (cnt_q != 2'd0) ? buf_q[rd_ptr_q] : in_item;

  assign o_m_valid = (cnt_q != 2'd0) || pend_q;
  assign o_m_data  = out_item.data;
  assign o_m_user  = out_item.user;
  assign o_m_last  = out_item.last;

  assign bypass = (cnt_q == 2'd0) && pend_q && i_m_ready;  // straight through when empty
  assign push   = pend_q && !bypass;
  assign pop    = (cnt_q != 2'd0) && i_m_ready;

  assign total   = cnt_q + {1'b0, pend_q};
  assign o_room  = (total < 2'd2);
  assign o_empty = (total == 2'd0);

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pend_q   <= 1'b0;
      cnt_q    <= 2'd0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      pend_q <= i_issue;
      cnt_q  <= cnt_q + {1'b0, push} - {1'b0, pop};
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_issue) begin
      pend_user_q <= i_user;
      pend_last_q <= i_last;
    end
    if (push) buf_q[wr_ptr_q] <= in_item;
  end

endmodule

`default_nettype wire

// File: verilog/weight_rotator.sv
// weight rotator top
// write controller, two weight banks, read controller, output buffer
`timescale 1ns/10ps
`default_nettype none

module weight_rotator (
  input  wire                     i_aclk,
  input  wire                     i_rst_n,
  input  wire                     i_s_valid,
  output logic                    o_s_ready,
  input  wire rotator_pkg::beat_t i_s_data,
  input  wire                     i_s_last,
  output logic                    o_m_valid,
  input  wire                     i_m_ready,
  output rotator_pkg::beat_t      o_m_data,
  output rotator_pkg::rot_user_t  o_m_user,
  output logic                    o_m_last
);

  rotator_pkg::rot_ref_t  ref0, ref1;
  rotator_pkg::addr_t     waddr, raddr;
  rotator_pkg::beat_t     bank_rdata [2];
  rotator_pkg::rot_user_t rd_user;
  logic [1:0]             wen, ren, full;
  logic                   rel, issue, rd_last, room, skid_empty;
  logic                   rd_sel_q;

  bank_write_ctrl u_write (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_s_valid (i_s_valid),
    .i_s_last  (i_s_last),
    .i_s_data  (i_s_data),
    .o_s_ready (o_s_ready),
    .o_wen     (wen),
    .o_waddr   (waddr),
    .o_full    (full),
    .o_ref0    (ref0),
    .o_ref1    (ref1),
    .i_release (rel)
  );

  for (genvar b = 0; b < 2; b++) begin : g_bank
    weight_bank u_bank (
      .i_aclk  (i_aclk),
      .i_rst_n (i_rst_n),
      .i_wen   (wen[b]),
      .i_waddr (waddr),
      .i_wdata (i_s_data),
      .i_ren   (ren[b]),
      .i_raddr (raddr),
      .o_rdata (bank_rdata[b])
    );
  end

  bank_read_ctrl u_read (
    .i_aclk       (i_aclk),
    .i_rst_n      (i_rst_n),
    .i_full       (full),
    .i_ref0       (ref0),
    .i_ref1       (ref1),
    .i_room       (room),
    .i_skid_empty (skid_empty),
    .o_ren        (ren),
    .o_raddr      (raddr),
    .o_issue      (issue),
    .o_user       (rd_user),
    .o_last       (rd_last),
    .o_release    (rel)
  );

  // data select follows the bank of the last read issue
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_sel_q <= 1'b0;
    end else if (ren != 2'b00) begin
      rd_sel_q <= ren[1];
    end
  end

  output_skid u_skid (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_issue   (issue),
    .i_data    (bank_rdata[rd_sel_q]),
    .i_user    (rd_user),
    .i_last    (rd_last),
    .o_room    (room),
    .o_empty   (skid_empty),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data),
    .o_m_user  (o_m_user),
    .o_m_last  (o_m_last)
  );

endmodule

`default_nettype wire

// File: tb/weight_rotator_tb.sv
// testbench for the weight rotator
// directed layer tests, reference queue from the rotation rules,
// compare tasks and per-wait timeouts
`timescale 1ns/10ps
`default_nettype none

`include "rotator_config.svh"

module weight_rotator_tb;

  logic                   i_aclk;
  logic                   i_rst_n;
  logic                   i_s_valid;
  logic                   o_s_ready;
  rotator_pkg::beat_t     i_s_data;
  logic                   i_s_last;
  logic                   o_m_valid;
  logic                   i_m_ready;
  rotator_pkg::beat_t     o_m_data;
  rotator_pkg::rot_user_t o_m_user;
  logic                   o_m_last;

  rotator_pkg::rot_out_t exp_q [$];            // expected output beats in order
  rotator_pkg::beat_t    wbuf [`ROT_BANK_DEPTH]; // weights of the layer being sent
  integer                seed = 32'h1a09;
  int                    beats_taken = 0;
  int                    hdr_taken_at = 0;     // output count when a header went in

  weight_rotator uut (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .i_s_last  (i_s_last),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data),
    .o_m_user  (o_m_user),
    .o_m_last  (o_m_last)
  );

  initial begin
    i_aclk = 1'b0;
    forever #50 i_aclk = ~i_aclk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_beat(input rotator_pkg::beat_t act, input rotator_pkg::beat_t exp,
                            input string what);
    if (act !== exp) begin
      stop_run($sformatf("[FAIL] time %0t: %s is %h, expected %h", $time, what, act, exp));
    end
  endtask

  task automatic check_user(input rotator_pkg::rot_user_t act,
                            input rotator_pkg::rot_user_t exp, input string what);
    if (act !== exp) begin
      stop_run($sformatf("[FAIL] time %0t: %s is %b, expected %b", $time, what, act, exp));
    end
  endtask

  task automatic check_last(input logic act, input logic exp);
    if (act !== exp) begin
      stop_run($sformatf("[FAIL] time %0t: o_m_last is %b, expected %b", $time, act, exp));
    end
  endtask

  // single control levels such as valid and ready
  task automatic check_bit(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      stop_run($sformatf("[FAIL] time %0t: %s is %b, expected %b", $time, what, act, exp));
    end
  endtask

  function automatic rotator_pkg::rot_ref_t make_ref(input int kw2, input int kh2,
                                                     input int cin_1, input int cols_1,
                                                     input int blocks_1);
    rotator_pkg::rot_ref_t r;
    r.kw2      = kw2[`ROT_KW2_BITS-1:0];
    r.kh2      = kh2[`ROT_KH2_BITS-1:0];
    r.cin_1    = cin_1[`ROT_CIN_BITS-1:0];
    r.cols_1   = cols_1[`ROT_COLS_BITS-1:0];
    r.blocks_1 = blocks_1[`ROT_BLOCKS_BITS-1:0];
    return r;
  endfunction

  function automatic int weight_count(input rotator_pkg::rot_ref_t hdr);
    return (2 * int'(hdr.kh2) + 1) * (int'(hdr.cin_1) + 1);
  endfunction

  function automatic int beat_count(input rotator_pkg::rot_ref_t hdr);
    return weight_count(hdr) * (int'(hdr.cols_1) + 1) * (int'(hdr.blocks_1) + 1);
  endfunction

  // one pass per column per block with blocks and columns counting down
  task automatic add_expected(input rotator_pkg::rot_ref_t hdr, input int n);
    rotator_pkg::rot_out_t item;
    int blk, col, i;
    for (blk = int'(hdr.blocks_1); blk >= 0; blk--) begin
      for (col = int'(hdr.cols_1); col >= 0; col--) begin
        for (i = 0; i < n; i++) begin
          item.data              = wbuf[i];
          item.user.kw2          = hdr.kw2;
          item.user.is_cin_last  = (i == n - 1);
          item.user.is_col_last  = (col == 0);
          item.user.is_top_block = (blk == int'(hdr.blocks_1));
          item.user.is_bot_block = (blk == 0);
          item.last              = (i == n - 1) && (col == 0) && (blk == 0);
          exp_q.push_back(item);
        end
      end
    end
  endtask

  // holds the beat until the handshake edge
  task automatic push_beat(input rotator_pkg::beat_t d, input logic last);
    int waited;
    waited = 0;
    i_s_valid <= 1'b1;
    i_s_data  <= d;
    i_s_last  <= last;
    @(posedge i_aclk);
    while (!o_s_ready) begin
      waited++;
      if (waited > 2000) stop_run("timeout waiting for o_s_ready on the input stream");
      @(posedge i_aclk);
    end
  endtask

  task automatic send_layer(input rotator_pkg::rot_ref_t hdr, input bit fresh);
    rotator_pkg::beat_t head;
    int n, i;
    n = weight_count(hdr);
    if (fresh) begin
      for (i = 0; i < n; i++) wbuf[i] = {$random(seed), $random(seed)};
    end
    add_expected(hdr, n);
    head = '0;
    head[$bits(rotator_pkg::rot_ref_t)-1:0] = hdr;
    @(posedge i_aclk);
    push_beat(head, 1'b0);
    hdr_taken_at = beats_taken;
    for (i = 0; i < n; i++) push_beat(wbuf[i], i == n - 1);
    i_s_valid <= 1'b0;
    i_s_last  <= 1'b0;
  endtask

  task automatic collect_beats(input int count, input bit gaps);
    rotator_pkg::rot_out_t exp_item;
    rotator_pkg::rot_out_t held;
    int got, idle;
    bit stalled;
    got     = 0;
    idle    = 0;
    stalled = 1'b0;
    i_m_ready <= 1'b1;
    while (got < count) begin
      @(posedge i_aclk);
      if (stalled) begin  // a refused beat must stay put
        check_bit(o_m_valid, 1'b1, "o_m_valid while stalled");
        check_beat(o_m_data, held.data, "o_m_data while stalled");
        check_user(o_m_user, held.user, "o_m_user while stalled");
        check_last(o_m_last, held.last);
      end
      if (o_m_valid && i_m_ready) begin
        if (exp_q.size() == 0) stop_run("an output beat arrived with no beat left to expect");
        exp_item = exp_q.pop_front();
        check_beat(o_m_data, exp_item.data, "o_m_data");
        check_user(o_m_user, exp_item.user, "o_m_user");
        check_last(o_m_last, exp_item.last);
        got++;
        beats_taken++;
        idle = 0;
      end else begin
        idle++;
        if (idle > 400) stop_run("timeout waiting for an output beat");
      end
      stalled   = o_m_valid && !i_m_ready;
      held.data = o_m_data;
      held.user = o_m_user;
      held.last = o_m_last;
      i_m_ready <= gaps ? (($random(seed) & 3) != 0) : 1'b1;  // about one gap in four
    end
    i_m_ready <= 1'b1;
  endtask

  task automatic verify_drained();
    repeat (10) begin
      @(posedge i_aclk);
      check_bit(o_m_valid, 1'b0, "o_m_valid after the final beat");
    end
    if (exp_q.size() != 0) stop_run("the DUT stopped with expected beats still missing");
  endtask

  task automatic single_beat_layer();
    @(posedge i_aclk);
    check_bit(o_m_valid, 1'b0, "o_m_valid after reset");
    send_layer(make_ref(1, 0, 0, 0, 0), 1'b1);
    collect_beats(1, 1'b0);
    verify_drained();
  endtask

  // also covers every flag and kw2 via the queue
  task automatic full_rotation();
    send_layer(make_ref(1, 1, 2, 3, 1), 1'b1);
    collect_beats(72, 1'b0);
    verify_drained();
  endtask

  task automatic ready_gaps();
    send_layer(make_ref(1, 1, 2, 3, 1), 1'b0);  // same weights again
    collect_beats(72, 1'b1);
    verify_drained();
  endtask

  task automatic back_to_back_layers();
    rotator_pkg::rot_ref_t ha, hb;
    ha = make_ref(2, 1, 2, 3, 1);
    hb = make_ref(2, 2, 3, 1, 2);
    fork
      begin
        send_layer(ha, 1'b1);
        send_layer(hb, 1'b1);
      end
      collect_beats(beat_count(ha) + beat_count(hb), 1'b1);
    join
    verify_drained();
  endtask

  task automatic third_layer_while_full();
    rotator_pkg::rot_ref_t ha, hb, hc;
    int base;
    ha = make_ref(3, 0, 3, 1, 1);
    hb = make_ref(1, 1, 1, 2, 0);
    hc = make_ref(0, 0, 4, 2, 0);
    base = beats_taken;
    @(posedge i_aclk);
    i_m_ready <= 1'b0;  // keep the reader from releasing
    send_layer(ha, 1'b1);
    send_layer(hb, 1'b1);
    repeat (20) begin
      @(posedge i_aclk);
      check_bit(o_s_ready, 1'b0, "o_s_ready with both banks full");
    end
    fork
      send_layer(hc, 1'b1);
      collect_beats(beat_count(ha) + beat_count(hb) + beat_count(hc), 1'b1);
    join
    if (hdr_taken_at - base < beat_count(ha)) begin
      stop_run("the third header went in before the first bank was drained");
    end
    verify_drained();
  endtask

  initial begin
    i_rst_n   = 1'b0;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_s_last  = 1'b0;
    i_m_ready = 1'b0;
    repeat (5) @(posedge i_aclk);
    check_bit(o_m_valid, 1'b0, "o_m_valid in reset");
    check_bit(o_s_ready, 1'b0, "o_s_ready in reset");
    i_rst_n <= 1'b1;
    single_beat_layer();
    full_rotation();
    ready_gaps();
    back_to_back_layers();
    third_layer_while_full();
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
verilog/rotator_pkg.sv
verilog/weight_bank.sv
verilog/bank_write_ctrl.sv
verilog/rotation_counter.sv
verilog/bank_read_ctrl.sv
verilog/output_skid.sv
verilog/weight_rotator.sv
tb/weight_rotator_tb.sv
